//--- include/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath width
`define XLEN 64

// register index width
`define REG_ADDR_W 5

// integer register count, x0 included
`define REG_COUNT 32

// instruction width
`define INSTR_W 32

`endif

//--- hdl/rvPkg.sv
package rvPkg;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        opImm    = 5'b00100,
        opAuipc  = 5'b00101,
        opImm32  = 5'b00110,
        opReg    = 5'b01100,
        opLui    = 5'b01101,
        opReg32  = 5'b01110,
        opBranch = 5'b11000,
        opJalr   = 5'b11001,
        opJal    = 5'b11011
    } opcodeE;

    typedef enum logic [4:0] {
        aluAdd, aluSub, aluSll, aluSrl, aluSra,
        aluAddW, aluSubW, aluSllW, aluSrlW, aluSraW,
        aluSlt, aluSltu, aluXor, aluOr, aluAnd,
        aluPassSrc2
    } aluOpE;

    // lt/ge signedness comes from the alu op
    typedef enum logic [2:0] {
        brNone, brEq, brNe, brLt, brGe, brJal, brJalr
    } branchE;

    typedef enum logic {
        src1Rs1, src1Pc
    } src1SelE;

    typedef enum logic [1:0] {
        src2Rs2, src2Imm, src2Four
    } src2SelE;

endpackage

//--- hdl/rvDecodeIf.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

interface rvDecodeIf;
    logic                    valid;
    logic [`XLEN-1:0]        pc;
    logic [`REG_ADDR_W-1:0]  rd;
    logic                    regWrEn;
    rvPkg::aluOpE            aluOp;
    rvPkg::src1SelE          src1Sel;
    rvPkg::src2SelE          src2Sel;
    rvPkg::branchE           branch;
    logic [`XLEN-1:0]        imm;
    logic [`XLEN-1:0]        rs1Data;
    logic [`XLEN-1:0]        rs2Data;

    modport decodeMp (
        output valid, pc, rd, regWrEn, aluOp, src1Sel, src2Sel, branch,
        output imm, rs1Data, rs2Data
    );

    modport executeMp (
        input valid, pc, rd, regWrEn, aluOp, src1Sel, src2Sel, branch,
        input imm, rs1Data, rs2Data
    );
endinterface

//--- hdl/rvDecoder.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rvDecoder (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    instrValid_i,
    input  logic [`INSTR_W-1:0]     instr_i,
    input  logic [`XLEN-1:0]        pc_i,
    output logic [`REG_ADDR_W-1:0]  rs1Addr_o,
    output logic [`REG_ADDR_W-1:0]  rs2Addr_o,
    input  logic [`XLEN-1:0]        rs1Data_i,
    input  logic [`XLEN-1:0]        rs2Data_i,
    output logic                    illegal_o,
    rvDecodeIf.decodeMp             dec
);

    rvPkg::opcodeE    opcode;
    logic [2:0]       funct3;
    logic             wordOp;
    logic [`XLEN-1:0] immI, immU, immB, immJ;

    rvPkg::aluOpE     aluOpD;
    rvPkg::src1SelE   src1SelD;
    rvPkg::src2SelE   src2SelD;
    rvPkg::branchE    branchD;
    logic             regWrEnD;
    logic             illegalD;
    logic [`XLEN-1:0] immD;

    // funct3 -> alu op, shared by reg and imm forms
    function automatic rvPkg::aluOpE aluFromFunct(input logic [2:0] f3, input logic alt,
                                                   input logic word);
        case (f3)
            3'b000:  return alt ? (word ? rvPkg::aluSubW : rvPkg::aluSub)
                                : (word ? rvPkg::aluAddW : rvPkg::aluAdd);
            3'b001:  return word ? rvPkg::aluSllW : rvPkg::aluSll;
            3'b010:  return rvPkg::aluSlt;
            3'b011:  return rvPkg::aluSltu;
            3'b100:  return rvPkg::aluXor;
            3'b101:  return alt ? (word ? rvPkg::aluSraW : rvPkg::aluSra)
                                : (word ? rvPkg::aluSrlW : rvPkg::aluSrl);
            3'b110:  return rvPkg::aluOr;
            default: return rvPkg::aluAnd;
        endcase
    endfunction

    assign opcode    = rvPkg::opcodeE'(instr_i[6:2]);
    assign funct3    = instr_i[14:12];
    assign wordOp    = (opcode == rvPkg::opReg32) || (opcode == rvPkg::opImm32);
    assign rs1Addr_o = instr_i[19:15];
    assign rs2Addr_o = instr_i[24:20];

    assign immI = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign immU = {{(`XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};
    assign immB = {{(`XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
    assign immJ = {{(`XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                   instr_i[30:21], 1'b0};

    always_comb begin
        aluOpD   = rvPkg::aluAdd;
        src1SelD = rvPkg::src1Rs1;
        src2SelD = rvPkg::src2Rs2;
        branchD  = rvPkg::brNone;
        regWrEnD = 1'b0;
        immD     = immI;
        illegalD = 1'b0;
        case (opcode)
            rvPkg::opReg, rvPkg::opReg32: begin
                regWrEnD = 1'b1;
                aluOpD   = aluFromFunct(funct3, instr_i[30], wordOp);
                // funct7 other than 0x00/0x20 is M extension, not here
                illegalD = (instr_i[31:25] != 7'h00) && (instr_i[31:25] != 7'h20);
            end
            rvPkg::opImm, rvPkg::opImm32: begin
                regWrEnD = 1'b1;
                src2SelD = rvPkg::src2Imm;
                aluOpD   = aluFromFunct(funct3, instr_i[30] && (funct3 == 3'b101), wordOp);
            end
            rvPkg::opLui: begin
                regWrEnD = 1'b1;
                src2SelD = rvPkg::src2Imm;
                immD     = immU;
                aluOpD   = rvPkg::aluPassSrc2;
            end
            rvPkg::opAuipc: begin
                regWrEnD = 1'b1;
                src1SelD = rvPkg::src1Pc;
                src2SelD = rvPkg::src2Imm;
                immD     = immU;
            end
            rvPkg::opJal, rvPkg::opJalr: begin
                regWrEnD = 1'b1;
                src1SelD = rvPkg::src1Pc;
                src2SelD = rvPkg::src2Four;   // link = pc + 4
                immD     = (opcode == rvPkg::opJal) ? immJ : immI;
                branchD  = (opcode == rvPkg::opJal) ? rvPkg::brJal : rvPkg::brJalr;
            end
            rvPkg::opBranch: begin
                immD    = immB;
                aluOpD  = funct3[1] ? rvPkg::aluSltu : rvPkg::aluSlt;
                case (funct3)
                    3'b000:  branchD = rvPkg::brEq;
                    3'b001:  branchD = rvPkg::brNe;
                    3'b100, 3'b110: branchD = rvPkg::brLt;
                    3'b101, 3'b111: branchD = rvPkg::brGe;
                    default: illegalD = 1'b1;
                endcase
            end
            default: illegalD = 1'b1;
        endcase
        // word forms only exist for add/sub and shifts
        if (wordOp && !(funct3 inside {3'b000, 3'b001, 3'b101}))
            illegalD = 1'b1;
        if (illegalD || instr_i[1:0] != 2'b11) begin
            illegalD = 1'b1;
            regWrEnD = 1'b0;
            branchD  = rvPkg::brNone;
        end
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            dec.valid <= 1'b0;
            illegal_o <= 1'b0;
        end else begin
            dec.valid <= instrValid_i;
            illegal_o <= instrValid_i & illegalD;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid_i) begin
            dec.pc      <= pc_i;
            dec.rd      <= instr_i[11:7];
            dec.regWrEn <= regWrEnD;
            dec.aluOp   <= aluOpD;
            dec.src1Sel <= src1SelD;
            dec.src2Sel <= src2SelD;
            dec.branch  <= branchD;
            dec.imm     <= immD;
            dec.rs1Data <= rs1Data_i;   // already bypassed
            dec.rs2Data <= rs2Data_i;
        end
    end

endmodule

//--- hdl/rvExecute.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rvExecute (
    rvDecodeIf.executeMp            ex,
    output logic                    wrEn_o,
    output logic [`REG_ADDR_W-1:0]  wrAddr_o,
    output logic [`XLEN-1:0]        wrData_o,
    output logic                    redirect_o,
    output logic [`XLEN-1:0]        target_o,
    output logic                    done_o
);

    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;
    logic [`XLEN-1:0] aluRes;
    logic [31:0]      wordRes;
    logic             isEq;
    logic             isLt;
    logic             taken;
    logic [`XLEN-1:0] jalrSum;

    assign op1 = (ex.src1Sel == rvPkg::src1Pc) ? ex.pc : ex.rs1Data;

    always_comb begin
        case (ex.src2Sel)
            rvPkg::src2Imm:  op2 = ex.imm;
            rvPkg::src2Four: op2 = `XLEN'd4;
            default:         op2 = ex.rs2Data;
        endcase
    end

    // word ops on low 32 bits, result sign-extended below
    always_comb begin
        case (ex.aluOp)
            rvPkg::aluSubW: wordRes = op1[31:0] - op2[31:0];
            rvPkg::aluSllW: wordRes = op1[31:0] << op2[4:0];
            rvPkg::aluSrlW: wordRes = op1[31:0] >> op2[4:0];
            rvPkg::aluSraW: wordRes = $signed(op1[31:0]) >>> op2[4:0];
            default:        wordRes = op1[31:0] + op2[31:0];
        endcase
    end

    always_comb begin
        case (ex.aluOp)
            rvPkg::aluAdd:      aluRes = op1 + op2;
            rvPkg::aluSub:      aluRes = op1 - op2;
            rvPkg::aluSll:      aluRes = op1 << op2[5:0];
            rvPkg::aluSrl:      aluRes = op1 >> op2[5:0];
            rvPkg::aluSra:      aluRes = $signed(op1) >>> op2[5:0];
            rvPkg::aluAddW, rvPkg::aluSubW, rvPkg::aluSllW, rvPkg::aluSrlW, rvPkg::aluSraW:
                aluRes = {{(`XLEN-32){wordRes[31]}}, wordRes};
            rvPkg::aluSlt:      aluRes = {{(`XLEN-1){1'b0}}, $signed(op1) < $signed(op2)};
            rvPkg::aluSltu:     aluRes = {{(`XLEN-1){1'b0}}, op1 < op2};
            rvPkg::aluXor:      aluRes = op1 ^ op2;
            rvPkg::aluOr:       aluRes = op1 | op2;
            rvPkg::aluAnd:      aluRes = op1 & op2;
            default:            aluRes = op2;   // passSrc2, lui
        endcase
    end

    // branch compare always on the register values
    assign isEq = ex.rs1Data == ex.rs2Data;
    assign isLt = (ex.aluOp == rvPkg::aluSltu) ? (ex.rs1Data < ex.rs2Data)
                                               : ($signed(ex.rs1Data) < $signed(ex.rs2Data));

    always_comb begin
        case (ex.branch)
            rvPkg::brEq:                taken = isEq;
            rvPkg::brNe:                taken = !isEq;
            rvPkg::brLt:                taken = isLt;
            rvPkg::brGe:                taken = !isLt;
            rvPkg::brJal, rvPkg::brJalr: taken = 1'b1;
            default:                    taken = 1'b0;
        endcase
    end

    assign jalrSum  = ex.rs1Data + ex.imm;
    assign target_o = (ex.branch == rvPkg::brJalr) ? {jalrSum[`XLEN-1:1], 1'b0}
                                                   : ex.pc + ex.imm;

    assign redirect_o = ex.valid & taken;
    assign wrEn_o     = ex.valid & ex.regWrEn;
    assign wrAddr_o   = ex.rd;
    assign wrData_o   = aluRes;
    assign done_o     = ex.valid;

endmodule

//--- hdl/rvRegFile.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rvRegFile (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic [`REG_ADDR_W-1:0]  rs1Addr_i,
    input  logic [`REG_ADDR_W-1:0]  rs2Addr_i,
    output logic [`XLEN-1:0]        rs1Data_o,
    output logic [`XLEN-1:0]        rs2Data_o,
    input  logic                    wrEn_i,
    input  logic [`REG_ADDR_W-1:0]  wrAddr_i,
    input  logic [`XLEN-1:0]        wrData_i,
    input  logic                    redirect_i,
    input  logic [`XLEN-1:0]        target_i,
    input  logic                    done_i,
    input  logic                    illegal_i,
    output logic                    wbValid_o,
    output logic [`REG_ADDR_W-1:0]  wbAddr_o,
    output logic [`XLEN-1:0]        wbData_o,
    output logic                    redirect_o,
    output logic [`XLEN-1:0]        nextPc_o,
    output logic                    illegal_o
);

    logic [`XLEN-1:0] regs [`REG_COUNT];
    logic             wrLive;

    assign wrLive = wrEn_i && (wrAddr_i != '0);   // x0 writes dropped

    // x0 reads zero, same-cycle write is forwarded
    function automatic logic [`XLEN-1:0] readPort(input logic [`REG_ADDR_W-1:0] addr);
        if (addr == '0)
            return '0;
        if (wrLive && wrAddr_i == addr)
            return wrData_i;
        return regs[addr];
    endfunction

    always_comb begin
        rs1Data_o = readPort(rs1Addr_i);
        rs2Data_o = readPort(rs2Addr_i);
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
            wbValid_o  <= 1'b0;
            redirect_o <= 1'b0;
            illegal_o  <= 1'b0;
        end else begin
            if (wrLive)
                regs[wrAddr_i] <= wrData_i;
            wbValid_o  <= wrLive;
            redirect_o <= redirect_i;
            illegal_o  <= done_i & illegal_i;
        end
    end

    always_ff @(posedge clk) begin
        if (wrLive) begin
            wbAddr_o <= wrAddr_i;
            wbData_o <= wrData_i;
        end
        if (redirect_i)
            nextPc_o <= target_i;
    end

endmodule

//--- hdl/rvCore.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rvCore (
    input  logic                    clk,
    input  logic                    rstN_i,
    input  logic                    instrValid_i,
    input  logic [`INSTR_W-1:0]     instr_i,
    input  logic [`XLEN-1:0]        pc_i,
    output logic                    wbValid_o,
    output logic [`REG_ADDR_W-1:0]  wbAddr_o,
    output logic [`XLEN-1:0]        wbData_o,
    output logic                    redirect_o,
    output logic [`XLEN-1:0]        nextPc_o,
    output logic                    illegal_o
);

    logic [`REG_ADDR_W-1:0] rs1Addr;
    logic [`REG_ADDR_W-1:0] rs2Addr;
    logic [`XLEN-1:0]       rs1Data;
    logic [`XLEN-1:0]       rs2Data;
    logic                   decIllegal;
    logic                   wrEn;
    logic [`REG_ADDR_W-1:0] wrAddr;
    logic [`XLEN-1:0]       wrData;
    logic                   exRedirect;
    logic [`XLEN-1:0]       exTarget;
    logic                   exDone;

    rvDecodeIf decIf ();

    rvDecoder u_decoder (
        .clk          (clk),
        .rstN_i       (rstN_i),
        .instrValid_i (instrValid_i),
        .instr_i      (instr_i),
        .pc_i         (pc_i),
        .rs1Addr_o    (rs1Addr),
        .rs2Addr_o    (rs2Addr),
        .rs1Data_i    (rs1Data),
        .rs2Data_i    (rs2Data),
        .illegal_o    (decIllegal),
        .dec          (decIf.decodeMp)
    );

    rvExecute u_execute (
        .ex           (decIf.executeMp),
        .wrEn_o       (wrEn),
        .wrAddr_o     (wrAddr),
        .wrData_o     (wrData),
        .redirect_o   (exRedirect),
        .target_o     (exTarget),
        .done_o       (exDone)
    );

    rvRegFile u_regFile (
        .clk          (clk),
        .rstN_i       (rstN_i),
        .rs1Addr_i    (rs1Addr),
        .rs2Addr_i    (rs2Addr),
        .rs1Data_o    (rs1Data),
        .rs2Data_o    (rs2Data),
        .wrEn_i       (wrEn),
        .wrAddr_i     (wrAddr),
        .wrData_i     (wrData),
        .redirect_i   (exRedirect),
        .target_i     (exTarget),
        .done_i       (exDone),
        .illegal_i    (decIllegal),
        .wbValid_o    (wbValid_o),
        .wbAddr_o     (wbAddr_o),
        .wbData_o     (wbData_o),
        .redirect_o   (redirect_o),
        .nextPc_o     (nextPc_o),
        .illegal_o    (illegal_o)
    );

endmodule

//--- sim/rvCore_chk.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rvCore_chk (
    input logic                   clk,
    input logic                   rstN_i,
    input logic                   wbValid_i,
    input logic [`REG_ADDR_W-1:0] wbAddr_i,
    input logic                   redirect_i,
    input logic                   illegal_i
);

    int unsigned assertFails = 0;

    quietAfterReset: assert property (@(posedge clk)
        $rose(rstN_i) |-> (!wbValid_i && !redirect_i && !illegal_i))
        else begin
            $error("outputs active right after reset release");
            assertFails++;
        end

    noWriteToX0: assert property (@(posedge clk) disable iff (!rstN_i)
        wbValid_i |-> (wbAddr_i != '0))
        else begin
            $error("writeback reported for x0");
            assertFails++;
        end

    // an illegal op never redirects
    redirectNotIllegal: assert property (@(posedge clk) disable iff (!rstN_i)
        !(redirect_i && illegal_i))
        else begin
            $error("redirect and illegal both set");
            assertFails++;
        end

endmodule

bind rvCore rvCore_chk u_chk (
    .clk        (clk),
    .rstN_i     (rstN_i),
    .wbValid_i  (wbValid_o),
    .wbAddr_i   (wbAddr_o),
    .redirect_i (redirect_o),
    .illegal_i  (illegal_o)
);

//--- sim/rvCoreScoreboard.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rvCoreScoreboard (
    input  logic                   clk,
    input  logic                   rstN_i,
    input  logic                   push_i,
    input  int                     idx_i,
    input  logic [2:0]             kind_i,
    input  logic [`REG_ADDR_W-1:0] rd_i,
    input  logic [`XLEN-1:0]       data_i,
    input  logic [`XLEN-1:0]       target_i,
    input  logic                   wbValid_i,
    input  logic [`REG_ADDR_W-1:0] wbAddr_i,
    input  logic [`XLEN-1:0]       wbData_i,
    input  logic                   redirect_i,
    input  logic [`XLEN-1:0]       nextPc_i,
    input  logic                   illegal_i,
    output int                     checked_o,
    output int                     errors_o
);

    // kind bit0 writeback, bit1 redirect, bit2 illegal
    typedef struct packed {
        int                     idx;
        int unsigned            due;
        logic [2:0]             kind;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       data;
        logic [`XLEN-1:0]       target;
    } expectT;

    expectT      pending [$];
    int unsigned cycle;

    task automatic compareResult(input expectT e, input logic [2:0] got);
        int bad;
        bad = 0;
        if (e.kind != 3'b000 && got == 3'b000) begin
            $display("t=%0t: instruction %0d gave no result, one was expected", $time, e.idx);
            bad = 1;
        end else if (e.kind == 3'b000 && got != 3'b000) begin
            $display("t=%0t: instruction %0d gave a result, none was expected", $time, e.idx);
            bad = 1;
        end else begin
            if (got != e.kind) begin
                $display("ERR t=%0t instr %0d: flags ill/redir/wb %b, expected %b",
                         $time, e.idx, got, e.kind);
                bad = 1;
            end
            if (e.kind[0] && (wbAddr_i != e.rd || wbData_i != e.data)) begin
                $display("ERR t=%0t instr %0d: wrote x%0d=%h, expected x%0d=%h",
                         $time, e.idx, wbAddr_i, wbData_i, e.rd, e.data);
                bad = 1;
            end
            if (e.kind[1] && nextPc_i != e.target) begin
                $display("ERR t=%0t instr %0d: redirect to %h, expected %h",
                         $time, e.idx, nextPc_i, e.target);
                bad = 1;
            end
        end
        checked_o++;
        if (bad != 0) begin
            errors_o++;
            $display("instr %0d done, mismatch", e.idx);
        end else begin
            $display("instr %0d done, ok", e.idx);
        end
    endtask

    // each result is due two sampling edges after its push
    always @(posedge clk) begin
        expectT     e;
        expectT     n;
        logic [2:0] got;
        got = {illegal_i, redirect_i, wbValid_i};
        if (!rstN_i) begin
            cycle     = 0;
            checked_o = 0;
            errors_o  = 0;
            pending.delete();
        end else begin
            cycle = cycle + 1;
            if (pending.size() > 0 && pending[0].due == cycle) begin
                e = pending.pop_front();
                compareResult(e, got);
            end else if (got != 3'b000) begin
                $display("t=%0t: DUT produced a result with no instruction due", $time);
                errors_o++;
            end
            if (push_i) begin
                n.idx    = idx_i;
                n.due    = cycle + 2;
                n.kind   = kind_i;
                n.rd     = rd_i;
                n.data   = data_i;
                n.target = target_i;
                pending.push_back(n);
            end
        end
    end

endmodule

//--- sim/rvCoreTb.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rvCoreTb;

    localparam int MaxEntries = 64;
    localparam int Cols       = 6;   // pc, instr, kind, rd, data, target

    logic                   clk;
    logic                   rstN;
    logic                   instrValid;
    logic [`INSTR_W-1:0]    instr;
    logic [`XLEN-1:0]       pc;
    logic                   wbValid;
    logic [`REG_ADDR_W-1:0] wbAddr;
    logic [`XLEN-1:0]       wbData;
    logic                   redirect;
    logic [`XLEN-1:0]       nextPc;
    logic                   illegal;

    // expected result, handed over with each instruction
    logic                   expPush;
    int                     expIdx;
    logic [2:0]             expKind;
    logic [`REG_ADDR_W-1:0] expRd;
    logic [`XLEN-1:0]       expData;
    logic [`XLEN-1:0]       expTarget;

    logic [63:0] vecMem [MaxEntries*Cols];
    int          numEntries;
    logic        loaded;
    int          checked;
    int          errors;

    rvCore u_dut (
        .clk          (clk),
        .rstN_i       (rstN),
        .instrValid_i (instrValid),
        .instr_i      (instr),
        .pc_i         (pc),
        .wbValid_o    (wbValid),
        .wbAddr_o     (wbAddr),
        .wbData_o     (wbData),
        .redirect_o   (redirect),
        .nextPc_o     (nextPc),
        .illegal_o    (illegal)
    );

    rvCoreScoreboard u_sb (
        .clk        (clk),
        .rstN_i     (rstN),
        .push_i     (expPush),
        .idx_i      (expIdx),
        .kind_i     (expKind),
        .rd_i       (expRd),
        .data_i     (expData),
        .target_i   (expTarget),
        .wbValid_i  (wbValid),
        .wbAddr_i   (wbAddr),
        .wbData_i   (wbData),
        .redirect_i (redirect),
        .nextPc_i   (nextPc),
        .illegal_i  (illegal),
        .checked_o  (checked),
        .errors_o   (errors)
    );

    always #2 clk = ~clk;

    // marks words the file did not overwrite
    function automatic logic [63:0] fillWord(input int addr);
        return {32'hdead_beef, 32'(addr)};
    endfunction

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        expPush    = 1'b0;
        expIdx     = 0;
        expKind    = '0;
        expRd      = '0;
        expData    = '0;
        expTarget  = '0;
        numEntries = 0;
        loaded     = 1'b0;
        for (int a = 0; a < MaxEntries*Cols; a++)
            vecMem[a] = fillWord(a);
        $readmemh("sim/rv_input.dat", vecMem);
        while (numEntries < MaxEntries &&
               vecMem[numEntries*Cols] != fillWord(numEntries*Cols))
            numEntries++;
        loaded = 1'b1;

        repeat (8) @(posedge clk);
        rstN <= 1'b1;

        // back to back, one instruction per clock
        for (int i = 0; i < numEntries; i++) begin
            @(posedge clk);
            instrValid <= 1'b1;
            pc         <= vecMem[i*Cols];
            instr      <= vecMem[i*Cols+1][31:0];
            expPush    <= 1'b1;
            expIdx     <= i;
            expKind    <= vecMem[i*Cols+2][2:0];
            expRd      <= vecMem[i*Cols+3][`REG_ADDR_W-1:0];
            expData    <= vecMem[i*Cols+4];
            expTarget  <= vecMem[i*Cols+5];
        end
        @(posedge clk);
        instrValid <= 1'b0;
        expPush    <= 1'b0;

        wait (checked == numEntries);
        repeat (4) @(posedge clk);   // room for stray results
        $display("%0d of %0d instructions checked, %0d errors, %0d assertion failures",
                 checked, numEntries, errors, u_dut.u_chk.assertFails);
        if (numEntries > 0 && checked == numEntries && errors == 0 &&
            u_dut.u_chk.assertFails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        #((numEntries + 20) * 4);
        $display("timeout: results still outstanding after %0t", $time);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- sim/rv_input.dat
// columns: pc instr kind rd wrdata target (hex), one instruction per line
// kind bit0 writeback, bit1 redirect, bit2 illegal; unused columns are zero
00001000 00500093 1 01 0000000000000005 0
00001004 FFD08113 1 02 0000000000000002 0
00001008 002081B3 1 03 0000000000000007 0
0000100C 40310233 1 04 FFFFFFFFFFFFFFFB 0
00001010 00421293 1 05 FFFFFFFFFFFFFFB0 0
00001014 4022D313 1 06 FFFFFFFFFFFFFFEC 0
00001018 03C2D393 1 07 000000000000000F 0
0000101C 7FFFF437 1 08 000000007FFFF000 0
00001020 008404BB 1 09 FFFFFFFFFFFFE000 0
00001024 80000537 1 0A FFFFFFFF80000000 0
00001028 4045559B 1 0B FFFFFFFFF8000000 0
00001030 401006BB 1 0D FFFFFFFFFFFFFFFB 0
00001034 00122733 1 0E 0000000000000001 0
0000103C FFF0C813 1 10 FFFFFFFFFFFFFFFA 0
00001044 0F087913 1 12 00000000000000F0 0
00001048 00108013 0 00 0000000000000000 0
00001050 12345A17 1 14 0000000012346050 0
00001054 010000EF 3 01 0000000000001058 00001064
00001064 005082E7 3 05 0000000000001068 0000105C
0000105C 00508463 0 00 0000000000000000 0
00001060 FE5098E3 2 00 0000000000000000 00001050
00001050 00124663 2 00 0000000000000000 0000105C
00001060 00127663 2 00 0000000000000000 0000106C
0000106C FE405CE3 2 00 0000000000000000 00001064
00001064 0000B183 4 00 0000000000000000 0
00001068 021081B3 4 00 0000000000000000 0
0000106C 00018A93 1 15 0000000000000007 0
00001070 00000073 4 00 0000000000000000 0
00001074 00D48B33 1 16 FFFFFFFFFFFFDFFB 0
00001078 FF9FF06F 2 00 0000000000000000 00001070

//--- sources.f
+incdir+include
hdl/rvPkg.sv
hdl/rvDecodeIf.sv
hdl/rvDecoder.sv
hdl/rvExecute.sv
hdl/rvRegFile.sv
hdl/rvCore.sv
sim/rvCore_chk.sv
sim/rvCoreScoreboard.sv
sim/rvCoreTb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator, run, and decide on the pass line
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sources.f --top-module rvCoreTb -o rvCoreSim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/rvCoreSim)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
